//--- src.f
design/cpuTypesPkg.sv
design/registerFile.sv
design/controlUnit.sv
design/aluUnit.sv
design/programCounter.sv
design/requestUnit.sv
design/datapath.sv
sim/memoryModel.sv
sim/datapathTb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, status follows the pass message
verilator --binary --timing -f src.f --top-module datapathTb -o datapathSim \
  && { ./obj_dir/datapathSim | tee /dev/stderr | grep -q "Regression passed"; } \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim/datapathTb.sv
`timescale 1ns/1ns

module datapathTb import cpuTypesPkg::*; ();

  logic CLK, nRST;
  word_t imemload, dmemload, imemaddr, dmemaddr, dmemstore;
  logic ihit, dhit, imemREN, dmemREN, dmemWEN, halt;

  word_t img [1024];
  word_t regs [32];
  word_t pcQ[$], sAddr[$], sData[$];
  int steps, fetchIdx, storesSeen, totalStores;
  logic served, rstDone, modelReady, prevStall;
  int checks [5];
  int errs [5];
  string names [5] = '{"resetState", "fetchAddr", "storeData", "waitStall", "haltState"};

  datapath i_datapath (
    .CLK(CLK), .nRST(nRST), .imemload(imemload), .ihit(ihit), .dmemload(dmemload),
    .dhit(dhit), .imemREN(imemREN), .imemaddr(imemaddr), .dmemREN(dmemREN),
    .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore), .halt(halt)
  );

  memoryModel memModel (
    .CLK(CLK), .nRST(nRST), .imemREN(imemREN), .imemaddr(imemaddr), .dmemREN(dmemREN),
    .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore), .imemload(imemload),
    .ihit(ihit), .dmemload(dmemload), .dhit(dhit)
  );

  always #4 CLK = ~CLK;

  task automatic checkValue(input int t, input word_t expV, input word_t actV);
    checks[t]++;
    assert (actV == expV) else begin
      errs[t]++;
      $display("Fail %s: expected %h, actual %h", names[t], expV, actV);
    end
  endtask

  task automatic checkTrue(input int t, input logic cond, input string what);
    checks[t]++;
    assert (cond) else begin
      errs[t]++;
      $display("Error in %s: %s", names[t], what);
    end
  endtask

  // ISA reference run over a copy of the program image
  task automatic runModel();
    word_t ins, pc, nextPc, simm, addr;
    opcode_t op;
    regIdx_t rs, rt, rd;
    pc = PC_INIT;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    steps = 0;
    while (steps < 2000) begin
      ins = img[pc[11:2]];
      pcQ.push_back(pc);
      steps++;
      op = opcode_t'(ins[31:26]);
      rs = ins[25:21];
      rt = ins[20:16];
      rd = ins[15:11];
      simm = {{16{ins[15]}}, ins[15:0]};
      nextPc = pc + 32'd4;
      addr = regs[rs] + simm;
      if (op == HALT) break;
      case (op)
        RTYPE: begin
          case (ins[5:0])
            SLL:  regs[rd] = regs[rt] << ins[10:6];
            SRL:  regs[rd] = regs[rt] >> ins[10:6];
            JR:   nextPc = regs[rs];
            ADDU: regs[rd] = regs[rs] + regs[rt];
            SUBU: regs[rd] = regs[rs] - regs[rt];
            AND:  regs[rd] = regs[rs] & regs[rt];
            OR:   regs[rd] = regs[rs] | regs[rt];
            XOR:  regs[rd] = regs[rs] ^ regs[rt];
            NOR:  regs[rd] = ~(regs[rs] | regs[rt]);
            SLT:  regs[rd] = {31'd0, $signed(regs[rs]) < $signed(regs[rt])};
            SLTU: regs[rd] = {31'd0, regs[rs] < regs[rt]};
            default: ;
          endcase
        end
        J: nextPc = {nextPc[31:28], ins[25:0], 2'b00};
        JAL: begin
          regs[31] = nextPc;  // link is pc + 4
          nextPc = {nextPc[31:28], ins[25:0], 2'b00};
        end
        BEQ: if (regs[rs] == regs[rt]) nextPc = nextPc + {simm[29:0], 2'b00};
        BNE: if (regs[rs] != regs[rt]) nextPc = nextPc + {simm[29:0], 2'b00};
        ADDIU: regs[rt] = addr;
        SLTI:  regs[rt] = {31'd0, $signed(regs[rs]) < $signed(simm)};
        SLTIU: regs[rt] = {31'd0, regs[rs] < simm};
        ANDI:  regs[rt] = regs[rs] & {16'd0, ins[15:0]};
        ORI:   regs[rt] = regs[rs] | {16'd0, ins[15:0]};
        XORI:  regs[rt] = regs[rs] ^ {16'd0, ins[15:0]};
        LUI:   regs[rt] = {ins[15:0], 16'd0};
        LW:    regs[rt] = img[addr[11:2]];
        SW: begin
          sAddr.push_back(addr);
          sData.push_back(regs[rt]);
          img[addr[11:2]] = regs[rt];
        end
        default: ;
      endcase
      regs[0] = '0;
      pc = nextPc;
    end
    totalStores = sData.size();
  endtask

  always @(posedge CLK) begin
    if (!nRST || !rstDone) begin
      // in reset and at the first edge after it
      checkValue(0, PC_INIT, imemaddr);
      checkTrue(0, !dmemREN && !dmemWEN, "data request high in reset");
      checkTrue(0, !halt, "halt high in reset");
      if (nRST) rstDone = 1'b1;
    end else begin
      if (ihit) begin
        if (fetchIdx < pcQ.size()) checkValue(1, pcQ[fetchIdx], imemaddr);
        else checkTrue(1, 1'b0, "fetch past the end of the program");
        if ((imemload[31:26] == LW || imemload[31:26] == SW) && !served) begin
          // refetched after the data hit
        end else if (imemload[31:26] != HALT) begin
          fetchIdx++;
          served = 1'b0;
        end
      end
      if (dhit) begin
        served = 1'b1;
        if (dmemWEN) begin
          storesSeen++;
          if (sAddr.size() > 0) begin
            checkValue(2, sAddr.pop_front(), dmemaddr);
            checkValue(2, sData.pop_front(), dmemstore);
          end else begin
            checkTrue(2, 1'b0, "store beyond the expected stores");
          end
        end
      end
      if (prevStall) begin
        checkTrue(3, dmemREN || dmemWEN, "data request dropped before dhit");
        // pc stays on the pending lw or sw
        if (fetchIdx < pcQ.size()) checkValue(3, pcQ[fetchIdx], imemaddr);
      end
      prevStall = (dmemREN || dmemWEN) && !dhit;
      if (halt) checkTrue(4, !imemREN, "imemREN high after halt");
    end
  end

  // limit scales with the executed instruction count
  initial begin
    wait (modelReady);
    #((steps * 40 + 20) * 8);
    $display("Timeout: no halt within 40 cycles per executed instruction");
    $display("Regression failed");
    $finish;
  end

  initial begin
    int total;
    int failed;
    CLK = 1'b0;
    nRST = 1'b0;
    served = 1'b0;
    rstDone = 1'b0;
    prevStall = 1'b0;
    modelReady = 1'b0;
    fetchIdx = 0;
    storesSeen = 0;
    #1;
    for (int i = 0; i < 1024; i++) img[i] = memModel.ram[i];
    runModel();
    modelReady = 1'b1;
    repeat (8) @(posedge CLK);
    #1 nRST = 1'b1;
    wait (halt);
    repeat (12) @(posedge CLK);
    checkValue(4, 32'(totalStores), 32'(storesSeen));
    checkTrue(4, halt, "halt fell before the end");
    total = 0;
    failed = 0;
    for (int t = 0; t < 5; t++) begin
      $display("test %s: %0d checks, %0d errors", names[t], checks[t], errs[t]);
      total += checks[t];
      failed += errs[t];
    end
    $display("checks %0d, errors %0d", total, failed);
    if (failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sim/memoryModel.sv
`timescale 1ns/1ns

module memoryModel import cpuTypesPkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  imemREN,
  input  word_t imemaddr,
  input  logic  dmemREN,
  input  logic  dmemWEN,
  input  word_t dmemaddr,
  input  word_t dmemstore,
  output word_t imemload,
  output logic  ihit,
  output word_t dmemload,
  output logic  dhit
);

  word_t ram [1024];
  int n;
  logic [15:0] off;
  int waitCnt;
  logic inReset;

  function automatic word_t iType(opcode_t op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t rType(regIdx_t rs, regIdx_t rt, regIdx_t rd, logic [4:0] sh,
                                  funct_t fn);
    return {RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t jType(opcode_t op, int target);
    return {op, target[25:0]};
  endfunction

  task automatic put(input word_t w);
    ram[n] = w;
    n++;
  endtask

  // every result goes to the next data word above 0x800
  task automatic storeReg(input regIdx_t r);
    put(iType(SW, 5'd10, r, off));
    off += 16'd4;
  endtask

  task automatic loadProgram();
    int k;
    int loopIdx;
    for (int i = 0; i < 1024; i++) begin
      ram[i] = word_t'(i) ^ 32'hbad0_0000;  // fill keyed to the word address
    end
    n = 0;
    off = 16'd0;
    put(iType(ADDIU, 5'd0, 5'd1, 16'($urandom)));
    put(iType(ADDIU, 5'd0, 5'd2, 16'($urandom)));
    put(iType(ADDIU, 5'd0, 5'd3, 16'($urandom)));
    put(iType(ADDIU, 5'd0, 5'd10, 16'h0800));  // data base
    put(iType(ADDIU, 5'd0, 5'd11, 16'd1));
    put(rType(5'd1, 5'd2, 5'd4, 5'd0, ADDU)); storeReg(5'd4);
    put(rType(5'd1, 5'd2, 5'd4, 5'd0, SUBU)); storeReg(5'd4);
    put(rType(5'd1, 5'd3, 5'd4, 5'd0, AND));  storeReg(5'd4);
    put(rType(5'd2, 5'd3, 5'd4, 5'd0, OR));   storeReg(5'd4);
    put(rType(5'd1, 5'd3, 5'd4, 5'd0, XOR));  storeReg(5'd4);
    put(rType(5'd1, 5'd2, 5'd4, 5'd0, NOR));  storeReg(5'd4);
    put(rType(5'd1, 5'd2, 5'd4, 5'd0, SLT));  storeReg(5'd4);
    put(rType(5'd2, 5'd3, 5'd4, 5'd0, SLTU)); storeReg(5'd4);
    put(rType(5'd0, 5'd2, 5'd4, 5'd5, SLL));  storeReg(5'd4);
    put(rType(5'd0, 5'd3, 5'd4, 5'd7, SRL));  storeReg(5'd4);
    put(iType(ADDIU, 5'd1, 5'd4, 16'($urandom))); storeReg(5'd4);
    put(iType(SLTI, 5'd2, 5'd4, 16'($urandom)));  storeReg(5'd4);
    put(iType(SLTIU, 5'd3, 5'd4, 16'($urandom))); storeReg(5'd4);
    put(iType(ANDI, 5'd1, 5'd4, 16'($urandom)));  storeReg(5'd4);
    put(iType(ORI, 5'd2, 5'd4, 16'($urandom)));   storeReg(5'd4);
    put(iType(XORI, 5'd3, 5'd4, 16'($urandom)));  storeReg(5'd4);
    put(iType(LUI, 5'd0, 5'd4, 16'($urandom)));   storeReg(5'd4);
    // read back the first result
    put(iType(LW, 5'd10, 5'd5, 16'd0));
    put(rType(5'd5, 5'd3, 5'd4, 5'd0, ADDU)); storeReg(5'd4);
    // countdown loop
    put(iType(ADDIU, 5'd0, 5'd6, 16'd3));
    loopIdx = n;
    put(iType(ADDIU, 5'd6, 5'd6, 16'hffff));
    put(rType(5'd7, 5'd6, 5'd7, 5'd0, ADDU));
    put(iType(BNE, 5'd6, 5'd0, 16'(loopIdx - n - 1)));
    storeReg(5'd7);
    put(iType(BEQ, 5'd0, 5'd0, 16'd1));  // taken
    put(iType(ADDIU, 5'd0, 5'd4, 16'h1234));
    storeReg(5'd4);
    put(iType(BEQ, 5'd0, 5'd11, 16'd1));  // not taken
    put(iType(ADDIU, 5'd0, 5'd4, 16'h5678));
    storeReg(5'd4);
    // call and return
    k = n;
    put(jType(JAL, k + 4));
    storeReg(5'd31);
    storeReg(5'd8);
    put(jType(J, k + 6));
    put(iType(ADDIU, 5'd1, 5'd8, 16'd1));
    put(rType(5'd31, 5'd0, 5'd0, 5'd0, JR));
    put({HALT, 26'd0});
  endtask

  assign imemload = ram[imemaddr[11:2]];
  assign dmemload = ram[dmemaddr[11:2]];

  initial begin
    ihit = 1'b0;
    dhit = 1'b0;
    waitCnt = 0;
    void'($urandom(19));
    loadProgram();
    forever begin
      @(posedge CLK);
      inReset = !nRST;
      if (dhit && dmemWEN) ram[dmemaddr[11:2]] = dmemstore;
      #1;
      ihit = 1'b0;
      dhit = 1'b0;
      if (inReset) begin
        waitCnt = 0;
      end else if (dmemREN || dmemWEN) begin
        if (waitCnt == 0) begin
          dhit = 1'b1;
          waitCnt = int'($urandom % 4);
        end else begin
          waitCnt--;
        end
      end else if (imemREN) begin
        // fetch only served with no data request open
        if (waitCnt == 0) begin
          ihit = 1'b1;
          waitCnt = int'($urandom % 4);
        end else begin
          waitCnt--;
        end
      end
    end
  end

endmodule

//--- design/datapath.sv
`timescale 1ns/1ns

module datapath import cpuTypesPkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t imemload,
  input  logic  ihit,
  input  word_t dmemload,
  input  logic  dhit,
  output logic  imemREN,
  output word_t imemaddr,
  output logic  dmemREN,
  output logic  dmemWEN,
  output word_t dmemaddr,
  output word_t dmemstore,
  output logic  halt
);

  word_t pc, pcPlus4, extImm;
  word_t rdat1, rdat2, wdat;
  word_t aluA, aluB, aluResult;
  regIdx_t wsel;
  aluOp_t aluOp;
  pcSel_t pcSel;
  logic aluSrcImm, zeroExt, shiftSel, regDst, regWrite, memToReg;
  logic lui, jal, dREN, dWEN, isHalt, aluZero;
  logic memOp, memDone, advance, regWen;

  controlUnit ctrl (
    .instr(imemload), .zero(aluZero), .aluOp(aluOp), .aluSrcImm(aluSrcImm),
    .zeroExt(zeroExt), .shiftSel(shiftSel), .regDst(regDst), .regWrite(regWrite),
    .memToReg(memToReg), .lui(lui), .jal(jal), .dREN(dREN), .dWEN(dWEN),
    .isHalt(isHalt), .pcSel(pcSel)
  );

  registerFile regFile (
    .CLK(CLK), .nRST(nRST), .wen(regWen), .wsel(wsel), .wdat(wdat),
    .rsel1(imemload[25:21]), .rsel2(imemload[20:16]), .rdat1(rdat1), .rdat2(rdat2)
  );

  aluUnit alu (
    .aluOp(aluOp), .portA(aluA), .portB(aluB), .result(aluResult), .zero(aluZero)
  );

  programCounter progCounter (
    .CLK(CLK), .nRST(nRST), .advance(advance), .pcSel(pcSel), .extImm(extImm),
    .jumpTarget(imemload[25:0]), .regTarget(rdat1), .pc(pc), .pcPlus4(pcPlus4)
  );

  // no new request once this instruction's access is served
  requestUnit reqUnit (
    .CLK(CLK), .nRST(nRST), .dREN(dREN & ~memDone), .dWEN(dWEN & ~memDone),
    .ihit(ihit), .dhit(dhit), .dmemREN(dmemREN), .dmemWEN(dmemWEN)
  );

  // immediate extender
  assign extImm = zeroExt ? {16'd0, imemload[15:0]} : {{16{imemload[15]}}, imemload[15:0]};

  assign aluA = shiftSel ? {27'd0, imemload[10:6]} : rdat1;  // shamt for sll/srl
  assign aluB = aluSrcImm ? extImm : rdat2;

  // write select and write data
  always_comb begin
    if (jal)
      wsel = LINK_REG;
    else if (regDst)
      wsel = imemload[15:11];  // rd
    else
      wsel = imemload[20:16];  // rt
  end

  always_comb begin
    if (lui)
      wdat = {imemload[15:0], 16'd0};
    else if (jal)
      wdat = pcPlus4;
    else if (memToReg)
      wdat = dmemload;
    else
      wdat = aluResult;
  end

  // loads write on dhit, everything else on ihit
  assign regWen = regWrite & ~halt & (memToReg ? dhit : ihit);

  assign memOp = dREN | dWEN;
  assign advance = ihit & ~halt & ~isHalt & ~dmemREN & ~dmemWEN & (~memOp | memDone);

  // marks a served lw/sw until the refetch moves the pc
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      memDone <= 1'b0;
    end else if (advance) begin
      memDone <= 1'b0;
    end else if (dhit) begin
      memDone <= 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (ihit && isHalt) begin
      halt <= 1'b1;  // sticky until reset
    end
  end

  assign imemREN = ~halt;
  assign imemaddr = pc;
  assign dmemaddr = aluResult;
  assign dmemstore = rdat2;

endmodule

//--- design/requestUnit.sv
`timescale 1ns/1ns

module requestUnit (
  input  logic CLK,
  input  logic nRST,
  input  logic dREN,
  input  logic dWEN,
  input  logic ihit,
  input  logic dhit,
  output logic dmemREN,
  output logic dmemWEN
);

  // requests are levels held until the memory answers
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      dmemREN <= 1'b0;
      dmemWEN <= 1'b0;
    end else if (dhit) begin
      dmemREN <= 1'b0;
      dmemWEN <= 1'b0;
    end else if (ihit) begin
      // raised by the fetch that presents lw or sw
      dmemREN <= dREN;
      dmemWEN <= dWEN;
    end
  end

endmodule

//--- design/programCounter.sv
`timescale 1ns/1ns

module programCounter import cpuTypesPkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        advance,
  input  pcSel_t      pcSel,
  input  word_t       extImm,
  input  logic [25:0] jumpTarget,
  input  word_t       regTarget,
  output word_t       pc,
  output word_t       pcPlus4
);

  word_t nextPc;
  word_t branchTarget;

  assign pcPlus4 = pc + 32'd4;
  assign branchTarget = pcPlus4 + {extImm[29:0], 2'b00};  // word offset

  always_comb begin
    case (pcSel)
      PC_BRANCH: nextPc = branchTarget;
      PC_JUMP:   nextPc = {pcPlus4[31:28], jumpTarget, 2'b00};
      PC_REG:    nextPc = regTarget;  // jr
      default:   nextPc = pcPlus4;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (advance) begin
      pc <= nextPc;
    end
  end

endmodule

//--- design/aluUnit.sv
`timescale 1ns/1ns

module aluUnit import cpuTypesPkg::*; (
  input  aluOp_t aluOp,
  input  word_t  portA,
  input  word_t  portB,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (aluOp)
      // shifts move portB by portA
      ALU_SLL: begin
        result = portB << portA[4:0];
      end
      ALU_SRL: begin
        result = portB >> portA[4:0];
      end
      ALU_ADD: begin
        result = portA + portB;
      end
      ALU_SUB: begin
        result = portA - portB;
      end
      ALU_AND: begin
        result = portA & portB;
      end
      ALU_OR: begin
        result = portA | portB;
      end
      ALU_XOR: begin
        result = portA ^ portB;
      end
      ALU_NOR: begin
        result = ~(portA | portB);
      end
      ALU_SLT: begin
        result = {31'd0, $signed(portA) < $signed(portB)};
      end
      ALU_SLTU: begin
        result = {31'd0, portA < portB};  // unsigned compare
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // used by beq and bne
  assign zero = (result == '0);

endmodule

//--- design/controlUnit.sv
`timescale 1ns/1ns

module controlUnit import cpuTypesPkg::*; (
  input  word_t  instr,
  input  logic   zero,
  output aluOp_t aluOp,
  output logic   aluSrcImm,
  output logic   zeroExt,
  output logic   shiftSel,
  output logic   regDst,
  output logic   regWrite,
  output logic   memToReg,
  output logic   lui,
  output logic   jal,
  output logic   dREN,
  output logic   dWEN,
  output logic   isHalt,
  output pcSel_t pcSel
);

  opcode_t opcode;
  funct_t funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct = funct_t'(instr[5:0]);

  always_comb begin
    // defaults give a no-op
    aluOp = ALU_ADD;
    aluSrcImm = 1'b0;
    zeroExt = 1'b0;
    shiftSel = 1'b0;
    regDst = 1'b0;
    regWrite = 1'b0;
    memToReg = 1'b0;
    lui = 1'b0;
    jal = 1'b0;
    dREN = 1'b0;
    dWEN = 1'b0;
    isHalt = 1'b0;
    pcSel = PC_SEQ;

    case (opcode)
      RTYPE: begin
        regDst = 1'b1;
        regWrite = 1'b1;
        case (funct)
          SLL: begin
            aluOp = ALU_SLL;
            shiftSel = 1'b1;  // shamt on port A
          end
          SRL: begin
            aluOp = ALU_SRL;
            shiftSel = 1'b1;
          end
          JR: begin
            regWrite = 1'b0;
            pcSel = PC_REG;
          end
          ADDU: aluOp = ALU_ADD;
          SUBU: aluOp = ALU_SUB;
          AND:  aluOp = ALU_AND;
          OR:   aluOp = ALU_OR;
          XOR:  aluOp = ALU_XOR;
          NOR:  aluOp = ALU_NOR;
          SLT:  aluOp = ALU_SLT;
          SLTU: aluOp = ALU_SLTU;
          default: regWrite = 1'b0;  // unknown funct does nothing
        endcase
      end
      J: pcSel = PC_JUMP;
      JAL: begin
        pcSel = PC_JUMP;
        jal = 1'b1;
        regWrite = 1'b1;
      end
      BEQ: begin
        aluOp = ALU_SUB;
        pcSel = zero ? PC_BRANCH : PC_SEQ;
      end
      BNE: begin
        aluOp = ALU_SUB;
        pcSel = zero ? PC_SEQ : PC_BRANCH;
      end
      ADDIU, SLTI, SLTIU, ANDI, ORI, XORI: begin
        aluSrcImm = 1'b1;
        regWrite = 1'b1;
        case (opcode)
          SLTI:    aluOp = ALU_SLT;
          SLTIU:   aluOp = ALU_SLTU;
          ANDI:    aluOp = ALU_AND;
          ORI:     aluOp = ALU_OR;
          XORI:    aluOp = ALU_XOR;
          default: aluOp = ALU_ADD;
        endcase
        zeroExt = (opcode == ANDI) || (opcode == ORI) || (opcode == XORI);  // logical ops only
      end
      LUI: begin
        lui = 1'b1;
        regWrite = 1'b1;
      end
      LW: begin
        aluSrcImm = 1'b1;
        regWrite = 1'b1;
        memToReg = 1'b1;
        dREN = 1'b1;
      end
      SW: begin
        aluSrcImm = 1'b1;
        dWEN = 1'b1;
      end
      HALT: isHalt = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- design/registerFile.sv
`timescale 1ns/1ns

module registerFile import cpuTypesPkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    wen,
  input  regIdx_t wsel,
  input  word_t   wdat,
  input  regIdx_t rsel1,
  input  regIdx_t rsel2,
  output word_t   rdat1,
  output word_t   rdat2
);

  word_t regs [32];

  // entry 0 is cleared at reset and never written
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != 5'd0)) begin
      regs[wsel] <= wdat;
    end
  end

  // reads are combinational
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

//--- design/cpuTypesPkg.sv
package cpuTypesPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regIdx_t;

  // reset vector and link register
  localparam word_t PC_INIT = 32'd0;
  localparam regIdx_t LINK_REG = 5'd31;

  // primary opcode, bits 31:26
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    SLTIU = 6'h0b,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f   // all ones
  } opcode_t;

  // r-type funct, bits 5:0
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL  = 4'd0,
    ALU_SRL  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_NOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluOp_t;

  // next pc source
  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JUMP   = 2'd2,
    PC_REG    = 2'd3
  } pcSel_t;

endpackage
